// File: backend_checker.sv
`default_nettype none

module backend_checker
  import pipe_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input logic    hold,
  input logic    flush,
  input ex_ls_t  ls_bundle,
  input retire_t retire
);

  int unsigned fail_count = 0;

  // nothing retires right after a reset cycle
  retire_after_reset: assert property (@(posedge clk) !rst_n |=> !retire.valid)
    else begin
      fail_count++;
      $error("retire.valid high after a reset cycle");
    end

  // flush without hold leaves a bubble
  flush_gives_bubble: assert property (@(posedge clk) flush && !hold |=> ls_bundle == '0)
    else begin
      fail_count++;
      $error("ls_bundle not cleared after flush");
    end

  hold_keeps_bundle: assert property (@(posedge clk) rst_n && hold |=> $stable(ls_bundle))
    else begin
      fail_count++;
      $error("ls_bundle changed while held");
    end

  legal_controls: assert property (@(posedge clk)
    rst_n |-> ls_bundle.lsctl <= ls_sd && ls_bundle.wbctl != 2'd3)
    else begin
      fail_count++;
      $error("illegal lsctl or wbctl in memory stage");
    end

endmodule

bind backend_top backend_checker i_backend_checker (
  .clk       (clk),
  .rst_n     (rst_n),
  .hold      (hold),
  .flush     (flush),
  .ls_bundle (ls_bundle),
  .retire    (retire)
);

`default_nettype wire

// File: backend_top.sv
`default_nettype none

module backend_top
  import pipe_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  ex_ls_t  ex_bundle,
  input  logic    hold,
  input  logic    flush,
  output retire_t retire,
  output fwd_t    ls_fwd
);

  ex_ls_t             ls_bundle;
  ls_wb_t             wb_next;
  logic [dmem_aw-1:0] mem_index;
  logic [xlen-1:0]    mem_wdata;
  logic [xlen-1:0]    mem_rdata;
  logic [7:0]         mem_be;
  logic               mem_we;

  ex_ls_reg i_ex_ls_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .ex_bundle (ex_bundle),
    .hold      (hold),
    .flush     (flush),
    .ls_bundle (ls_bundle)
  );

  // memory stage
  lsu i_lsu (
    .ls_bundle (ls_bundle),
    .mem_index (mem_index),
    .mem_wdata (mem_wdata),
    .mem_be    (mem_be),
    .mem_we    (mem_we),
    .mem_rdata (mem_rdata),
    .wb_next   (wb_next),
    .ls_fwd    (ls_fwd)
  );

  dmem i_dmem (
    .clk   (clk),
    .index (mem_index),
    .wdata (mem_wdata),
    .be    (mem_be),
    .we    (mem_we),
    .rdata (mem_rdata)
  );

  ls_wb_reg i_ls_wb_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_next (wb_next),
    .retire  (retire)
  );

endmodule

`default_nettype wire

// File: dmem.sv
`default_nettype none

module dmem
  import pipe_pkg::*;
(
  input  logic               clk,
  input  logic [dmem_aw-1:0] index,
  input  logic [xlen-1:0]    wdata,
  input  logic [7:0]         be,
  input  logic               we,
  output logic [xlen-1:0]    rdata
);

  logic [xlen-1:0] mem [dmem_words];

  initial begin
    for (int i = 0; i < dmem_words; i++) begin
      mem[i] = '0;
    end
  end

  // byte-lane write, untouched lanes keep their old bytes
  always_ff @(posedge clk) begin
    if (we) begin
      for (int b = 0; b < 8; b++) begin
        if (be[b]) begin
          mem[index][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
  end

  // read is combinational, sees every earlier write
  assign rdata = mem[index];

endmodule

`default_nettype wire

// File: ex_ls_reg.sv
`default_nettype none

module ex_ls_reg
  import pipe_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  ex_ls_t ex_bundle,
  input  logic   hold,
  input  logic   flush,
  output ex_ls_t ls_bundle
);

  ex_ls_t bundle_q;

  // hold wins over flush, flush leaves a bubble with zero control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bundle_q <= '0;
    end else if (hold) begin
      bundle_q <= bundle_q;
    end else if (flush) begin
      bundle_q <= '0;
    end else begin
      bundle_q <= ex_bundle;
    end
  end

  assign ls_bundle = bundle_q;

endmodule

`default_nettype wire

// File: ls_wb_reg.sv
`default_nettype none

module ls_wb_reg
  import pipe_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  ls_wb_t  wb_next,
  output retire_t retire
);

  retire_t retire_q;

  // no hold here, a held instruction simply retires again
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retire_q <= '0;
    end else begin
      retire_q.valid   <= wb_next.rd_ena;
      retire_q.inst    <= wb_next.inst;
      retire_q.pc      <= wb_next.pc;
      retire_q.rd_addr <= wb_next.rd_addr;
      retire_q.rd_data <= wb_select(wb_next.wbctl, wb_next.exu_res,
                                    wb_next.load_data, wb_next.pc);
    end
  end

  assign retire = retire_q;

endmodule

`default_nettype wire

// File: lsu.sv
`default_nettype none

module lsu
  import pipe_pkg::*;
(
  input  ex_ls_t             ls_bundle,
  output logic [dmem_aw-1:0] mem_index,
  output logic [xlen-1:0]    mem_wdata,
  output logic [7:0]         mem_be,
  output logic               mem_we,
  input  logic [xlen-1:0]    mem_rdata,
  output ls_wb_t             wb_next,
  output fwd_t               ls_fwd
);

  logic [2:0]      byte_off;
  logic [5:0]      bit_off;
  logic            is_store;
  logic [xlen-1:0] rdata_shifted;
  logic [xlen-1:0] load_data;

  // address taken as naturally aligned
  assign byte_off  = ls_bundle.exu_res[2:0];
  assign bit_off   = {byte_off, 3'b000};
  assign mem_index = ls_bundle.exu_res[dmem_aw+2:3];

  assign is_store = ls_bundle.lsctl inside {ls_sb, ls_sh, ls_sw, ls_sd};
  assign mem_we   = is_store;

  // byte enables per store width
  always_comb begin
    case (ls_bundle.lsctl)
      ls_sb:   mem_be = 8'h01 << byte_off;
      ls_sh:   mem_be = 8'h03 << byte_off;
      ls_sw:   mem_be = 8'h0f << byte_off;
      ls_sd:   mem_be = 8'hff;
      default: mem_be = 8'h00;
    endcase
  end

  // store data moved up into its lanes
  assign mem_wdata = ls_bundle.store_data << bit_off;

  // addressed bytes moved down to bit 0
  assign rdata_shifted = mem_rdata >> bit_off;

  always_comb begin
    case (ls_bundle.lsctl)
      ls_none: begin
        load_data = '0;
      end
      ls_lb: begin
        load_data = {{(xlen-8){rdata_shifted[7]}}, rdata_shifted[7:0]};
      end
      ls_lh: begin
        load_data = {{(xlen-16){rdata_shifted[15]}}, rdata_shifted[15:0]};
      end
      ls_lw: begin
        load_data = {{(xlen-32){rdata_shifted[31]}}, rdata_shifted[31:0]};
      end
      ls_ld: begin
        load_data = rdata_shifted;
      end
      ls_lbu: begin
        load_data = {{(xlen-8){1'b0}}, rdata_shifted[7:0]};
      end
      ls_lhu: begin
        load_data = {{(xlen-16){1'b0}}, rdata_shifted[15:0]};
      end
      ls_lwu: begin
        load_data = {{(xlen-32){1'b0}}, rdata_shifted[31:0]};
      end
      // stores and illegal codes load nothing
      default: begin
        load_data = '0;
      end
    endcase
  end

  always_comb begin
    wb_next.inst      = ls_bundle.inst;
    wb_next.pc        = ls_bundle.pc;
    wb_next.exu_res   = ls_bundle.exu_res;
    wb_next.load_data = load_data;
    wb_next.wbctl     = ls_bundle.wbctl;
    wb_next.rd_ena    = ls_bundle.rd_ena;
    wb_next.rd_addr   = ls_bundle.rd_addr;
  end

  // forward from here, the loaded value already exists
  always_comb begin
    ls_fwd.rd_ena  = ls_bundle.rd_ena;
    ls_fwd.rd_addr = ls_bundle.rd_addr;
    ls_fwd.rd_data = wb_select(ls_bundle.wbctl, ls_bundle.exu_res, load_data,
                               ls_bundle.pc);
  end

endmodule

`default_nettype wire

// File: pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  localparam int xlen       = 64;
  localparam int dmem_words = 256;
  localparam int dmem_aw    = $clog2(dmem_words);

  // load/store control codes
  localparam logic [3:0] ls_none = 4'd0;
  localparam logic [3:0] ls_lb   = 4'd1;
  localparam logic [3:0] ls_lh   = 4'd2;
  localparam logic [3:0] ls_lw   = 4'd3;
  localparam logic [3:0] ls_ld   = 4'd4;
  localparam logic [3:0] ls_lbu  = 4'd5;
  localparam logic [3:0] ls_lhu  = 4'd6;
  localparam logic [3:0] ls_lwu  = 4'd7;
  localparam logic [3:0] ls_sb   = 4'd8;
  localparam logic [3:0] ls_sh   = 4'd9;
  localparam logic [3:0] ls_sw   = 4'd10;
  localparam logic [3:0] ls_sd   = 4'd11;

  // writeback source, 3 is illegal
  localparam logic [1:0] wb_alu  = 2'd0;
  localparam logic [1:0] wb_mem  = 2'd1;
  localparam logic [1:0] wb_link = 2'd2;

  typedef struct packed {
    logic [31:0]     inst;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] store_data;
    logic [xlen-1:0] exu_res;
    logic [3:0]      lsctl;
    logic [1:0]      wbctl;
    logic            rd_ena;
    logic [4:0]      rd_addr;
  } ex_ls_t;

  typedef struct packed {
    logic [31:0]     inst;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] exu_res;
    logic [xlen-1:0] load_data;
    logic [1:0]      wbctl;
    logic            rd_ena;
    logic [4:0]      rd_addr;
  } ls_wb_t;

  typedef struct packed {
    logic            valid;
    logic [31:0]     inst;
    logic [xlen-1:0] pc;
    logic [4:0]      rd_addr;
    logic [xlen-1:0] rd_data;
  } retire_t;

  typedef struct packed {
    logic            rd_ena;
    logic [4:0]      rd_addr;
    logic [xlen-1:0] rd_data;
  } fwd_t;

  // writeback value select, shared by the forward path and the retire register
  function automatic logic [xlen-1:0] wb_select(
    input logic [1:0]      wbctl,
    input logic [xlen-1:0] exu_res,
    input logic [xlen-1:0] load_data,
    input logic [xlen-1:0] pc
  );
    logic [xlen-1:0] sel;
    case (wbctl)
      wb_alu:  sel = exu_res;
      wb_mem:  sel = load_data;
      wb_link: sel = pc + xlen'(4);
      default: sel = exu_res;
    endcase
    return sel;
  endfunction

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_backend -o tb_backend
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_backend +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: PASSED" "$log"; then
  exit 0
else
  exit 1
fi

// File: sim.f
pipe_pkg.sv
ex_ls_reg.sv
dmem.sv
lsu.sv
ls_wb_reg.sv
backend_top.sv
backend_checker.sv
tb_backend.sv

// File: tb_backend.sv
`default_nettype none

module tb_backend
  import pipe_pkg::*;
();

  localparam int clk_period      = 100;
  localparam int reset_cycles    = 16;
  localparam int test_cycles     = 2700;
  localparam int mid_reset_at    = 1500;
  localparam int mid_reset_len   = 4;
  localparam int margin_cycles   = 284;
  localparam int watchdog_cycles = reset_cycles + test_cycles + margin_cycles;

  logic    clk;
  logic    rst_n;
  logic    hold;
  logic    flush;
  ex_ls_t  ex_bundle;
  retire_t retire;
  fwd_t    ls_fwd;

  integer  seed = 32'h319c2c2c;

  // reference model state
  ex_ls_t          model_ls;
  retire_t         exp_retire;
  logic [xlen-1:0] model_mem [dmem_words];

  backend_top i_backend_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .ex_bundle (ex_bundle),
    .hold      (hold),
    .flush     (flush),
    .retire    (retire),
    .ls_fwd    (ls_fwd)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic fail_run();
    $display("Result: FAILED");
    $fatal(1, "stopping at first failure");
  endtask

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles without the test finishing",
             watchdog_cycles);
    fail_run();
  end

  function automatic int access_bytes(input logic [3:0] code);
    case (code)
      ls_lb, ls_lbu, ls_sb: return 1;
      ls_lh, ls_lhu, ls_sh: return 2;
      ls_lw, ls_lwu, ls_sw: return 4;
      ls_ld, ls_sd:         return 8;
      default:              return 0;
    endcase
  endfunction

  function automatic logic is_load(input logic [3:0] code);
    return code >= ls_lb && code <= ls_lwu;
  endfunction

  function automatic logic is_store(input logic [3:0] code);
    return code >= ls_sb && code <= ls_sd;
  endfunction

  // bytes from the addressed lanes, then sign fill for lb, lh and lw
  function automatic logic [xlen-1:0] load_value(input ex_ls_t b, input logic [xlen-1:0] word);
    logic [xlen-1:0] val;
    int              n;
    int              off;
    val = '0;
    n   = access_bytes(b.lsctl);
    off = int'(b.exu_res[2:0]);
    if (is_load(b.lsctl)) begin
      for (int i = 0; i < n; i++) begin
        val[i*8 +: 8] = word[(off+i)*8 +: 8];
      end
      if ((b.lsctl inside {ls_lb, ls_lh, ls_lw}) && val[n*8-1]) begin
        val = val | ({xlen{1'b1}} << (n * 8));
      end
    end
    return val;
  endfunction

  function automatic logic [xlen-1:0] wb_value(input ex_ls_t b, input logic [xlen-1:0] ld);
    case (b.wbctl)
      wb_mem:  return ld;
      wb_link: return b.pc + 64'd4;
      default: return b.exu_res;
    endcase
  endfunction

  function automatic fwd_t expected_fwd();
    fwd_t f;
    f.rd_ena  = model_ls.rd_ena;
    f.rd_addr = model_ls.rd_addr;
    f.rd_data = wb_value(model_ls, load_value(model_ls, model_mem[model_ls.exu_res[10:3]]));
    return f;
  endfunction

  task automatic apply_store(input ex_ls_t b);
    int n;
    int off;
    n   = access_bytes(b.lsctl);
    off = int'(b.exu_res[2:0]);
    if (is_store(b.lsctl)) begin
      for (int i = 0; i < n; i++) begin
        model_mem[b.exu_res[10:3]][(off+i)*8 +: 8] = b.store_data[i*8 +: 8];
      end
    end
  endtask

  // one rising edge of the model, inputs are the ones driven last cycle
  task automatic step_model();
    logic [xlen-1:0] word;
    word               = model_mem[model_ls.exu_res[10:3]];
    exp_retire.valid   = model_ls.rd_ena;
    exp_retire.inst    = model_ls.inst;
    exp_retire.pc      = model_ls.pc;
    exp_retire.rd_addr = model_ls.rd_addr;
    exp_retire.rd_data = wb_value(model_ls, load_value(model_ls, word));
    if (!rst_n) begin
      exp_retire = '0;
    end
    // a store in the memory stage lands even on a reset edge
    apply_store(model_ls);
    if (!rst_n) begin
      model_ls = '0;
    end else if (!hold) begin
      model_ls = flush ? '0 : ex_bundle;
    end
  endtask

  task automatic make_bundle(output ex_ls_t b);
    int n;
    b.inst       = $random(seed);
    b.pc         = {$random(seed), $random(seed)};
    b.store_data = {$random(seed), $random(seed)};
    b.exu_res    = {$random(seed), $random(seed)};
    b.lsctl      = 4'($unsigned($random(seed)) % 12);
    b.wbctl      = 2'($unsigned($random(seed)) % 3);
    b.rd_ena     = 1'($random(seed));
    b.rd_addr    = 5'($random(seed));
    n = access_bytes(b.lsctl);
    // memory ops stay inside 2 KB, aligned to size
    if (n != 0) begin
      b.exu_res      = {53'd0, 11'($random(seed))};
      b.exu_res[2:0] = b.exu_res[2:0] & ~3'(n - 1);
    end
    // loads mostly write back what they read
    if (is_load(b.lsctl) && ($unsigned($random(seed)) % 4) != 0) begin
      b.wbctl = wb_mem;
    end
  endtask

  task automatic drive_inputs(input int n);
    ex_ls_t b;
    logic   in_reset;
    in_reset = (n < reset_cycles) ||
               (n >= mid_reset_at && n < mid_reset_at + mid_reset_len);
    rst_n = !in_reset;
    hold  = ($unsigned($random(seed)) % 8) == 0;
    flush = ($unsigned($random(seed)) % 10) == 0;
    make_bundle(b);
    ex_bundle = b;
  endtask

  task automatic check_retire(input retire_t got, input retire_t exp);
    if (got !== exp) begin
      $display("Error: retire got %h expected %h", got, exp);
      fail_run();
    end
  endtask

  task automatic check_fwd(input fwd_t got, input fwd_t exp);
    if (got !== exp) begin
      $display("Error: ls_fwd got %h expected %h", got, exp);
      fail_run();
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    hold       = 1'b0;
    flush      = 1'b0;
    ex_bundle  = '0;
    model_ls   = '0;
    exp_retire = '0;
    for (int i = 0; i < dmem_words; i++) begin
      model_mem[i] = '0;
    end
    for (int cyc = 0; cyc < reset_cycles + test_cycles; cyc++) begin
      @(posedge clk);
      step_model();
      #10;
      check_retire(retire, exp_retire);
      check_fwd(ls_fwd, expected_fwd());
      if (i_backend_top.i_backend_checker.fail_count != 0) begin
        $display("an assertion in the backend checker failed at cycle %0d", cyc);
        fail_run();
      end
      drive_inputs(cyc + 1);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
